// File: sim.f
scan_pkg.sv
frame_rx.sv
crc32_check.sv
arp_patt.sv
ip_patt.sv
l4_patt.sv
udp_port_cam.sv
scanner.sv
tb_scanner.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_scanner
FILELIST = sim.f
OBJDIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf $(OBJDIR)

// File: tb_scanner.sv
// Testbench for the receive frame classifier
// Builds frames from a table, models both memories and checks status and data
`default_nettype none

module tb_scanner;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PORT_AW = 3;
	localparam int WATCHDOG = 100000;

	// Frame kinds
	localparam int K_ARP = 0;
	localparam int K_ICMP = 1;
	localparam int K_UDP6000 = 2;
	localparam int K_UDP5000 = 3;

	// Corruption selectors
	localparam int C_NONE = 0;
	localparam int C_PAYLOAD = 1;
	localparam int C_PHYERR = 2;
	localparam int C_DMAC = 3;
	localparam int C_DIP = 4;
	localparam int C_TTL0 = 5;
	localparam int C_HCSUM = 6;
	localparam int C_SPORT = 7;
	localparam int C_DPORT = 8;
	localparam int C_PRE = 9;

	logic clk;
	logic rst_n;
	logic [7:0] eth_in;
	logic eth_in_s;
	logic eth_in_e;
	logic enable_rx;
	logic [3:0] ip_a;
	logic [7:0] ip_d;
	logic [PORT_AW:0] pno_a;
	logic [7:0] pno_d;
	logic [7:0] odata;
	logic odata_s;
	logic odata_f;
	logic status_valid;
	logic [PORT_AW+4:0] status_vec;
	logic [scan_pkg::CNT_W-1:0] pack_len;

	logic [7:0] cfg_mem[16];
	logic [7:0] port_mem[16];
	logic [7:0] frame_q[$];
	logic [7:0] rx_q[$];
	int sv_count;
	logic [PORT_AW+4:0] last_vec;
	logic [scan_pkg::CNT_W-1:0] last_len;

	// Stimulus table, one entry per frame
	int row_kind[$];
	int row_cor[$];
	int row_gap[$];
	int row_en[$];
	int row_vec[$];
	int row_len[$];

	scanner #(.PORT_AW(PORT_AW)) u_scanner (
		.clk(clk), .rst_n(rst_n), .eth_in(eth_in), .eth_in_s(eth_in_s),
		.eth_in_e(eth_in_e), .enable_rx(enable_rx), .ip_a(ip_a), .ip_d(ip_d),
		.pno_a(pno_a), .pno_d(pno_d), .odata(odata), .odata_s(odata_s),
		.odata_f(odata_f), .status_valid(status_valid), .status_vec(status_vec),
		.pack_len(pack_len)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Both memories answer one cycle after the address
	always @(posedge clk) begin
		ip_d <= cfg_mem[ip_a];
		pno_d <= port_mem[pno_a];
	end

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// Output monitor
	always @(posedge clk) begin
		if (rst_n) begin
			check_eq(32'(odata_f), 32'(status_valid), "odata_f against status_valid");
			if (odata_s)
				rx_q.push_back(odata);
			if (status_valid) begin
				sv_count <= sv_count + 1;
				last_vec <= status_vec;
				last_len <= pack_len;
			end
		end
	end

	function automatic void add_row(input int kind, input int cor, input int gap, input int en,
		input int vec, input int len);
		row_kind.push_back(kind);
		row_cor.push_back(cor);
		row_gap.push_back(gap);
		row_en.push_back(en);
		row_vec.push_back(vec);
		row_len.push_back(len);
	endfunction

	// IEEE 802.3 FCS over the frame so far, complemented
	function automatic logic [31:0] frame_fcs();
		logic [31:0] c;
		int i;
		int k;
		c = 32'hffffffff;
		for (i = 0; i < frame_q.size(); i++) begin
			c = c ^ {24'd0, frame_q[i]};
			for (k = 0; k < 8; k++)
				c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
		end
		return ~c;
	endfunction

	// IPv4 header checksum over octets 14 to 33
	function automatic logic [15:0] ip_checksum();
		logic [31:0] s;
		int i;
		s = 0;
		for (i = 14; i < 34; i += 2)
			s = s + {16'd0, frame_q[i], frame_q[i+1]};
		s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
		s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
		return ~s[15:0];
	endfunction

	function automatic void build_frame(input int r);
		int kind;
		int cor;
		int i;
		logic [15:0] dport;
		logic [15:0] csum;
		logic [31:0] fcs;
		kind = row_kind[r];
		cor = row_cor[r];
		frame_q.delete();
		// Destination and source MAC
		frame_q.push_back(8'h02);
		for (i = 0; i < 4; i++)
			frame_q.push_back(8'h00);
		frame_q.push_back(cor == C_DMAC ? 8'h03 : 8'h01);
		frame_q.push_back(8'h02);
		for (i = 0; i < 4; i++)
			frame_q.push_back(8'h00);
		frame_q.push_back(8'h02);
		if (kind == K_ARP) begin
			frame_q = {frame_q, 8'h08, 8'h06, 8'h00, 8'h01, 8'h08, 8'h00, 8'h06, 8'h04};
			frame_q = {frame_q, 8'h00, 8'h01};
			// Sender MAC and IP, then zero target MAC
			frame_q = {frame_q, 8'h02, 8'h00, 8'h00, 8'h00, 8'h00, 8'h02};
			frame_q = {frame_q, 8'hc0, 8'ha8, 8'h01, 8'h14};
			for (i = 0; i < 6; i++)
				frame_q.push_back(8'h00);
			frame_q = {frame_q, 8'hc0, 8'ha8, 8'h01};
			frame_q.push_back(cor == C_DIP ? 8'h0b : 8'h0a);
		end else begin
			// IPv4 header, total length 38, DF set
			frame_q = {frame_q, 8'h08, 8'h00, 8'h45, 8'h00, 8'h00, 8'd38, 8'h00, 8'h00};
			frame_q = {frame_q, 8'h40, 8'h00};
			frame_q.push_back(cor == C_TTL0 ? 8'h00 : 8'h40);
			frame_q.push_back(kind == K_ICMP ? 8'd1 : 8'd17);
			frame_q = {frame_q, 8'h00, 8'h00, 8'hc0, 8'ha8, 8'h01, 8'h14};
			frame_q = {frame_q, 8'hc0, 8'ha8, 8'h01};
			frame_q.push_back(cor == C_DIP ? 8'h0b : 8'h0a);
			csum = ip_checksum();
			frame_q[24] = csum[15:8];
			frame_q[25] = (cor == C_HCSUM) ? (csum[7:0] ^ 8'h01) : csum[7:0];
			if (kind == K_ICMP) begin
				frame_q = {frame_q, 8'h08, 8'h00, 8'h00, 8'h00, 8'h00, 8'h01, 8'h00, 8'h01};
			end else begin
				dport = (kind == K_UDP6000) ? 16'd6000 : 16'd5000;
				if (cor == C_DPORT)
					dport = 16'd7000;
				// Source port 1000 sits below the allowed range
				frame_q.push_back(cor == C_SPORT ? 8'h03 : 8'h0f);
				frame_q.push_back(cor == C_SPORT ? 8'he8 : 8'ha0);
				frame_q = {frame_q, dport[15:8], dport[7:0], 8'h00, 8'd18, 8'h00, 8'h00};
			end
			for (i = 0; i < 10; i++)
				frame_q.push_back(8'h30 + 8'(i));
		end
		// Pad to minimum size, then the FCS low octet first
		while (frame_q.size() < 60)
			frame_q.push_back(8'h00);
		fcs = frame_fcs();
		frame_q = {frame_q, fcs[7:0], fcs[15:8], fcs[23:16], fcs[31:24]};
		if (cor == C_PAYLOAD)
			frame_q[45] = frame_q[45] ^ 8'h04;
	endfunction

	task automatic send_octet(input logic [7:0] b, input logic s, input logic e);
		@(posedge clk);
		eth_in <= b;
		eth_in_s <= s;
		eth_in_e <= e;
	endtask

	task automatic send_frame(input int r);
		int i;
		int pre_len;
		// Short gaps also get a one-octet preamble so idle plus preamble stays short
		pre_len = (row_gap[r] < scan_pkg::IFG_MIN) ? 1 : 7;
		for (i = 0; i < row_gap[r]; i++)
			send_octet(8'h00, 1'b0, 1'b0);
		@(posedge clk);
		enable_rx <= row_en[r][0];
		for (i = 0; i < pre_len; i++)
			send_octet((row_cor[r] == C_PRE && i == 3) ? 8'h54 : 8'h55, 1'b1, 1'b0);
		send_octet(8'hd5, 1'b1, 1'b0);
		for (i = 0; i < frame_q.size(); i++)
			send_octet(frame_q[i], 1'b1, row_cor[r] == C_PHYERR && i == 40);
		send_octet(8'h00, 1'b0, 1'b0);
		enable_rx <= 1'b1;
	endtask

	task automatic run_row(input int r);
		int n0;
		int q0;
		int t;
		int i;
		build_frame(r);
		n0 = sv_count;
		q0 = rx_q.size();
		send_frame(r);
		if (row_len[r] == 0) begin
			// Dropped frame, nothing may come out
			repeat (20) @(posedge clk);
			check_eq(32'(sv_count - n0), 0, "status pulses for a dropped frame");
			check_eq(32'(rx_q.size() - q0), 0, "octets forwarded for a dropped frame");
		end else begin
			t = 0;
			while (sv_count == n0 && t < 30) begin
				@(posedge clk);
				t++;
			end
			if (sv_count == n0) begin
				$display("Timeout waiting for status_valid on frame %0d", r);
				$display("Simulation failed");
				$fatal(1);
			end
			check_eq(32'(last_vec), 32'(row_vec[r]), $sformatf("status_vec of frame %0d", r));
			check_eq(32'(last_len), 32'(row_len[r]), $sformatf("pack_len of frame %0d", r));
			check_eq(32'(last_len), 32'(frame_q.size()), "pack_len against octets sent");
			check_eq(32'(rx_q.size() - q0), 32'(frame_q.size()), "forwarded octet count");
			for (i = 0; i < frame_q.size(); i++)
				check_eq(32'(rx_q[q0 + i]), 32'(frame_q[i]), $sformatf("odata octet %0d", i));
		end
	endtask

	initial begin
		int a;
		int r;
		rst_n = 1'b0;
		eth_in = 8'h00;
		eth_in_s = 1'b0;
		eth_in_e = 1'b0;
		enable_rx = 1'b1;
		ip_d = 8'h00;
		pno_d = 8'h00;
		sv_count = 0;
		// Fill never matches a MAC, an IP octet or a listed port
		for (a = 0; a < 16; a++) begin
			cfg_mem[a] = 8'he0 | 8'(a);
			port_mem[a] = 8'hf0 | 8'(a);
		end
		cfg_mem[0] = 8'h02;
		cfg_mem[1] = 8'h00;
		cfg_mem[2] = 8'h00;
		cfg_mem[3] = 8'h00;
		cfg_mem[4] = 8'h00;
		cfg_mem[5] = 8'h01;
		cfg_mem[8] = 8'hc0;
		cfg_mem[9] = 8'ha8;
		cfg_mem[10] = 8'h01;
		cfg_mem[11] = 8'h0a;
		// Port 5000 at entry 2, 6000 at entry 5
		port_mem[4] = 8'h13;
		port_mem[5] = 8'h88;
		port_mem[10] = 8'h17;
		port_mem[11] = 8'h70;
		// Status bits: port index, IP, MAC, CRC, category
		add_row(K_ARP, C_NONE, 12, 1, 8'h0d, 64);
		add_row(K_ICMP, C_NONE, 12, 1, 8'h1e, 64);
		add_row(K_UDP6000, C_NONE, 12, 1, 8'hbf, 64);
		add_row(K_UDP5000, C_NONE, 12, 1, 8'h5f, 64);
		add_row(K_UDP6000, C_PAYLOAD, 12, 1, 8'h08, 64);
		add_row(K_ICMP, C_PHYERR, 12, 1, 8'h08, 64);
		add_row(K_UDP6000, C_DMAC, 12, 1, 8'h04, 64);
		add_row(K_ARP, C_DMAC, 12, 1, 8'h05, 64);
		add_row(K_ICMP, C_DIP, 12, 1, 8'h0c, 64);
		add_row(K_ARP, C_DIP, 12, 1, 8'h0c, 64);
		add_row(K_UDP6000, C_TTL0, 12, 1, 8'h0c, 64);
		add_row(K_ICMP, C_HCSUM, 12, 1, 8'h0c, 64);
		add_row(K_UDP6000, C_SPORT, 12, 1, 8'h1c, 64);
		add_row(K_UDP6000, C_DPORT, 12, 1, 8'h1c, 64);
		// Drops, each followed by a good frame
		add_row(K_UDP5000, C_NONE, 12, 0, 0, 0);
		add_row(K_UDP6000, C_NONE, 12, 1, 8'hbf, 64);
		add_row(K_ICMP, C_NONE, 1, 1, 0, 0);
		add_row(K_UDP5000, C_NONE, 12, 1, 8'h5f, 64);
		add_row(K_ARP, C_PRE, 12, 1, 0, 0);
		add_row(K_ICMP, C_NONE, 12, 1, 8'h1e, 64);
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		for (r = 0; r < row_kind.size(); r++)
			run_row(r);
		repeat (5) @(posedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

	initial begin
		repeat (WATCHDOG) @(posedge clk);
		$display("Timeout: the run did not finish in time");
		$display("Simulation failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

// File: scanner.sv
// Receive frame classifier top level
// Matches addresses against the config memory and reports category and status
`default_nettype none

module scanner #(
	parameter int PORT_AW = 3
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [7:0]                 eth_in,
	input  logic                       eth_in_s,
	input  logic                       eth_in_e,
	input  logic                       enable_rx,
	output logic [3:0]                 ip_a,
	input  logic [7:0]                 ip_d,
	output logic [PORT_AW:0]           pno_a,
	input  logic [7:0]                 pno_d,
	output logic [7:0]                 odata,
	output logic                       odata_s,
	output logic                       odata_f,
	output logic                       status_valid,
	output logic [PORT_AW+4:0]         status_vec,
	output logic [scan_pkg::CNT_W-1:0] pack_len
);

	localparam int CNT_W = scan_pkg::CNT_W;
	localparam int OFF_DMAC = scan_pkg::OFF_DST_MAC;
	localparam int OFF_IPD = scan_pkg::OFF_IP_DST;
	localparam int OFF_TIP = scan_pkg::OFF_ARP_TIP;

	logic [7:0] octet;
	logic [CNT_W-1:0] idx;
	logic [CNT_W-1:0] nxt;
	logic oct_v;
	logic oct_first;
	logic oct_last;
	logic oct_err;
	logic crc_ok;
	logic arp_pass;
	logic ip_pass;
	logic icmp_pass;
	logic udp_pass;
	logic udp_port_stb;
	logic port_hit;
	logic [PORT_AW-1:0] port_idx;
	logic [15:0] ip_length;
	logic in_mac;
	logic in_ipd;
	logic in_tip;
	logic cfg_m;
	logic mac_ok;
	logic ip_dst_ok;
	logic arp_ip_ok;
	logic src_uni;
	logic ip_len_ok;
	logic pass_arp;
	logic pass_ip;
	logic pass_icmp;
	logic pass_udp;
	logic [1:0] category;

	frame_rx u_frame_rx (
		.clk(clk), .rst_n(rst_n), .eth_in(eth_in), .eth_in_s(eth_in_s),
		.eth_in_e(eth_in_e), .enable_rx(enable_rx), .octet(octet), .idx(idx),
		.oct_v(oct_v), .oct_first(oct_first), .oct_last(oct_last),
		.oct_err(oct_err), .pack_len(pack_len)
	);

	crc32_check u_crc (
		.clk(clk), .rst_n(rst_n), .oct_v(oct_v), .oct_first(oct_first),
		.oct_err(oct_err), .octet(octet), .crc_ok(crc_ok)
	);

	arp_patt u_arp (.clk(clk), .rst_n(rst_n), .idx(idx), .octet(octet), .pass(arp_pass));

	ip_patt u_ip (
		.clk(clk), .rst_n(rst_n), .idx(idx), .octet(octet),
		.pass(ip_pass), .ip_length(ip_length)
	);

	l4_patt u_l4 (
		.clk(clk), .rst_n(rst_n), .idx(idx), .octet(octet), .ip_length(ip_length),
		.icmp_pass(icmp_pass), .udp_pass(udp_pass), .udp_port_stb(udp_port_stb)
	);

	udp_port_cam #(.PORT_AW(PORT_AW)) u_cam (
		.clk(clk), .rst_n(rst_n), .port_stb(udp_port_stb), .octet(octet),
		.pno_a(pno_a), .pno_d(pno_d), .port_hit(port_hit), .port_idx(port_idx)
	);

	// Config address leads the stream by one octet
	// idx is all ones between frames, so nxt points at octet 0
	assign nxt = idx + 1'b1;

	always_comb begin
		if (nxt >= OFF_IPD && nxt < OFF_IPD + 4)
			ip_a = scan_pkg::CFG_IP_BASE + 4'(nxt - OFF_IPD);
		else if (nxt >= OFF_TIP && nxt < OFF_TIP + 4)
			ip_a = scan_pkg::CFG_IP_BASE + 4'(nxt - OFF_TIP);
		else
			ip_a = scan_pkg::CFG_MAC_BASE + nxt[3:0];
	end

	// Compare windows for the current octet
	assign in_mac = idx >= OFF_DMAC && idx < OFF_DMAC + 6;
	assign in_ipd = idx >= OFF_IPD && idx < OFF_IPD + 4;
	assign in_tip = idx >= OFF_TIP && idx < OFF_TIP + 4;
	assign cfg_m = ip_d == octet;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mac_ok <= 1'b0;
			ip_dst_ok <= 1'b0;
			arp_ip_ok <= 1'b0;
			src_uni <= 1'b0;
		end else begin
			// Octet 0 both presets and compares
			if (idx == '0)
				mac_ok <= ~in_mac | cfg_m;
			else if (in_mac && !cfg_m)
				mac_ok <= 1'b0;
			if (idx == '0)
				ip_dst_ok <= 1'b1;
			else if (in_ipd && !cfg_m)
				ip_dst_ok <= 1'b0;
			if (idx == '0)
				arp_ip_ok <= 1'b1;
			else if (in_tip && !cfg_m)
				arp_ip_ok <= 1'b0;
			// Group bit of the source MAC must be clear
			if (idx == CNT_W'(scan_pkg::OFF_SRC_MAC))
				src_uni <= ~octet[0];
		end
	end

	// Frame carries at least the IP datagram plus header and FCS
	assign ip_len_ok = {6'd0, pack_len} >= {1'b0, ip_length} + 17'd18;

	// Summary, meaningful at oct_last
	assign pass_arp = src_uni & crc_ok & arp_pass & arp_ip_ok;
	assign pass_ip = src_uni & crc_ok & mac_ok & ip_pass & ip_dst_ok & ip_len_ok;
	assign pass_icmp = pass_ip & icmp_pass;
	assign pass_udp = pass_ip & udp_pass & port_hit;

	always_comb begin
		if (pass_udp)
			category = scan_pkg::CAT_UDP;
		else if (pass_icmp)
			category = scan_pkg::CAT_ICMP;
		else if (pass_arp)
			category = scan_pkg::CAT_ARP;
		else
			category = scan_pkg::CAT_OTHER;
	end

	assign status_vec = {pass_udp ? port_idx : '0, pass_ip, mac_ok, crc_ok, category};

	assign odata = octet;
	assign odata_s = oct_v;
	assign odata_f = oct_last;
	assign status_valid = oct_last;

endmodule

`default_nettype wire

// File: udp_port_cam.sv
// Sequential CAM over the local UDP port table
// Two reads per entry, stops at the first matching port
`default_nettype none

module udp_port_cam #(
	parameter int PORT_AW = 3
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               port_stb,
	input  logic [7:0]         octet,
	output logic [PORT_AW:0]   pno_a,
	input  logic [7:0]         pno_d,
	output logic               port_hit,
	output logic [PORT_AW-1:0] port_idx
);

	localparam int AW = PORT_AW + 1;

	logic [7:0] prev_q;
	logic [15:0] port_q;
	logic busy;
	logic [AW-1:0] addr;
	logic rd_v;
	logic [AW-1:0] rd_a;
	logic [7:0] hi_q;
	logic match;

	// Even address is the high octet, odd the low
	assign pno_a = addr;
	assign match = rd_v && rd_a[0] && !port_hit && ({hi_q, pno_d} == port_q);

	always_ff @(posedge clk) begin
		prev_q <= octet;
		if (port_stb)
			port_q <= {prev_q, octet};
		if (rd_v && !rd_a[0])
			hi_q <= pno_d;
		rd_a <= addr;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			addr <= '0;
			rd_v <= 1'b0;
			port_hit <= 1'b0;
			port_idx <= '0;
		end else begin
			rd_v <= busy & ~port_stb;
			if (port_stb) begin
				busy <= 1'b1;
				addr <= '0;
				port_hit <= 1'b0;
			end else begin
				if (busy) begin
					addr <= addr + 1'b1;
					if (addr == '1)
						busy <= 1'b0;
				end
				// First hit ends the walk
				if (match) begin
					port_hit <= 1'b1;
					port_idx <= rd_a[AW-1:1];
					busy <= 1'b0;
				end
			end
		end
	end

	a_hit_idle: assert property (@(posedge clk) disable iff (!rst_n) port_hit |-> !busy);

endmodule

`default_nettype wire

// File: l4_patt.sv
// ICMP echo request and UDP header checks
// Also strobes the CAM with the low octet of the UDP destination port
`default_nettype none

module l4_patt (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [scan_pkg::CNT_W-1:0] idx,
	input  logic [7:0]                 octet,
	input  logic [15:0]                ip_length,
	output logic                       icmp_pass,
	output logic                       udp_pass,
	output logic                       udp_port_stb
);

	localparam int OFF_PROTO = 23;
	localparam int OFF_L4 = 34;
	localparam int OFF_ULEN = scan_pkg::OFF_UDP_DPORT + 2;

	logic [7:0] prev_q;
	logic [15:0] udp_len;
	logic icmp_bad;
	logic udp_bad;

	// Previous octet pairs with the current one for 16-bit fields
	always_ff @(posedge clk)
		prev_q <= octet;

	assign udp_len = {prev_q, octet};

	// Type 8 code 0 under protocol 1
	assign icmp_bad = (idx == OFF_PROTO && octet != 8'd1) ||
		(idx == OFF_L4 && octet != 8'h08) ||
		(idx == OFF_L4 + 1 && octet != 8'h00);

	// Protocol 17, source port 1024 and up, destination port nonzero,
	// UDP length fits inside the IP payload
	assign udp_bad = (idx == OFF_PROTO && octet != 8'd17) ||
		(idx == OFF_L4 && octet[7:2] == 6'd0) ||
		(idx == scan_pkg::OFF_UDP_DPORT + 1 && udp_len == 16'd0) ||
		(idx == OFF_ULEN + 1 && ({1'b0, udp_len} + 17'd20 > {1'b0, ip_length}));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			icmp_pass <= 1'b0;
			udp_pass <= 1'b0;
		end else if (idx == '0) begin
			icmp_pass <= 1'b1;
			udp_pass <= 1'b1;
		end else begin
			if (icmp_bad)
				icmp_pass <= 1'b0;
			if (udp_bad)
				udp_pass <= 1'b0;
		end
	end

	assign udp_port_stb = idx == scan_pkg::CNT_W'(scan_pkg::OFF_UDP_DPORT + 1);

endmodule

`default_nettype wire

// File: ip_patt.sv
// IPv4 header check
// Fixed fields, nonzero TTL, header checksum and total length capture
`default_nettype none

module ip_patt (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [scan_pkg::CNT_W-1:0] idx,
	input  logic [7:0]                 octet,
	output logic                       pass,
	output logic [15:0]                ip_length
);

	logic [7:0] tmpl;
	logic [7:0] mask;
	logic want;
	logic ttl_zero;
	logic pass_r;
	logic in_hdr;
	logic [7:0] hi_q;
	logic [15:0] sum;
	logic [16:0] wide;
	logic [15:0] fold;

	always_comb begin
		want = 1'b1;
		mask = 8'hff;
		case (idx)
			12: tmpl = 8'h08;  // Ethertype IPv4
			13: tmpl = 8'h00;
			14: tmpl = 8'h45;  // Version 4, IHL 5, no options
			20: begin
				// Flags and fragment offset, DF allowed
				tmpl = 8'h00;
				mask = 8'hbf;
			end
			21: tmpl = 8'h00;
			default: begin
				tmpl = 8'h00;
				want = 1'b0;
			end
		endcase
	end

	assign ttl_zero = (idx == 22) && (octet == 8'h00);

	always_ff @(posedge clk) begin
		if (!rst_n)
			pass_r <= 1'b0;
		else if (idx == '0)
			pass_r <= 1'b1;
		else if ((want && (octet & mask) != tmpl) || ttl_zero)
			pass_r <= 1'b0;
	end

	// Header words are even/odd octet pairs from 14 to 33
	assign in_hdr = idx >= 14 && idx <= 33;
	assign wide = {1'b0, sum} + {1'b0, hi_q, octet};
	// End-around carry
	assign fold = wide[15:0] + 16'(wide[16]);

	always_ff @(posedge clk) begin
		if (in_hdr && !idx[0])
			hi_q <= octet;
		// Total length sits in octets 16 and 17
		if (idx == 17)
			ip_length <= {hi_q, octet};
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			sum <= '0;
		else if (idx == '0)
			sum <= '0;
		else if (in_hdr && idx[0])
			sum <= fold;
	end

	// A correct header folds to all ones
	assign pass = pass_r & (sum == 16'hffff);

endmodule

`default_nettype wire

// File: arp_patt.sv
// ARP request template check
// Ethertype, hardware and protocol types, address lengths and opcode
`default_nettype none

module arp_patt (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [scan_pkg::CNT_W-1:0] idx,
	input  logic [7:0]                 octet,
	output logic                       pass
);

	logic [7:0] tmpl;
	logic want;

	always_comb begin
		want = 1'b1;
		case (idx)
			12: tmpl = 8'h08;  // Ethertype ARP
			13: tmpl = 8'h06;
			14: tmpl = 8'h00;  // Hardware type Ethernet
			15: tmpl = 8'h01;
			16: tmpl = 8'h08;  // Protocol type IPv4
			17: tmpl = 8'h00;
			18: tmpl = 8'h06;  // MAC length
			19: tmpl = 8'h04;  // IP length
			20: tmpl = 8'h00;  // Opcode request
			21: tmpl = 8'h01;
			default: begin
				tmpl = 8'h00;
				want = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pass <= 1'b0;
		else if (idx == '0)
			pass <= 1'b1;
		else if (want && octet != tmpl)
			pass <= 1'b0;
	end

endmodule

`default_nettype wire

// File: crc32_check.sv
// IEEE 802.3 CRC-32 checker, one octet per clock
// Runs over data and FCS, then compares against the fixed residue
`default_nettype none

module crc32_check (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       oct_v,
	input  logic       oct_first,
	input  logic       oct_err,
	input  logic [7:0] octet,
	output logic       crc_ok
);

	localparam logic [31:0] CRC_POLY = 32'hedb88320;

	logic [31:0] crc;
	logic err;

	// Reflected LFSR, LSB of the octet first
	function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		int i;
		r = c;
		for (i = 0; i < 8; i++)
			r = (r[0] ^ d[i]) ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
		return r;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			crc <= '1;
			err <= 1'b0;
		end else begin
			// Seed with all ones on octet 0
			if (oct_first)
				crc <= crc_step('1, octet);
			else if (oct_v)
				crc <= crc_step(crc, octet);
			// PHY error or oversize cut sticks until the next frame
			if (oct_first)
				err <= oct_err;
			else if (oct_err)
				err <= 1'b1;
		end
	end

	assign crc_ok = (crc == scan_pkg::CRC_RESIDUE) & ~err;

endmodule

`default_nettype wire

// File: frame_rx.sv
// GMII receive framing
// Preamble/SFD hunt, inter-frame gap, oversize drop and a two-stage octet stream
`default_nettype none

module frame_rx (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [7:0]                 eth_in,
	input  logic                       eth_in_s,
	input  logic                       eth_in_e,
	input  logic                       enable_rx,
	output logic [7:0]                 octet,
	output logic [scan_pkg::CNT_W-1:0] idx,
	output logic                       oct_v,
	output logic                       oct_first,
	output logic                       oct_last,
	output logic                       oct_err,
	output logic [scan_pkg::CNT_W-1:0] pack_len
);

	localparam int CNT_W = scan_pkg::CNT_W;
	localparam int GAP_W = $clog2(scan_pkg::IFG_MIN + 1);
	localparam logic [7:0] PRE_OCT = 8'h55;
	localparam logic [7:0] SFD_OCT = 8'hd5;

	// One-hot framing states
	localparam logic [3:0] ST_IDLE = 4'b0001;
	localparam logic [3:0] ST_PRE = 4'b0010;
	localparam logic [3:0] ST_DATA = 4'b0100;
	localparam logic [3:0] ST_DROP = 4'b1000;

	logic [3:0] state;
	logic [GAP_W-1:0] gap;
	logic gap_ok;
	logic [CNT_W-1:0] cnt;
	logic at_max;
	logic dat;
	logic ovf_now;
	// Stage 1 of the octet pipe
	logic [7:0] d1;
	logic [CNT_W-1:0] idx1;
	logic v1;
	logic e1;
	logic ovf1;
	logic err2;

	assign gap_ok = gap >= GAP_W'(scan_pkg::IFG_MIN);
	assign at_max = cnt == CNT_W'(scan_pkg::MAX_FRAME);
	assign dat = (state == ST_DATA) & eth_in_s & ~at_max;
	assign ovf_now = (state == ST_DATA) & eth_in_s & at_max;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					// Receive enable sampled on the first preamble octet only
					if (eth_in_s)
						state <= (eth_in == PRE_OCT && enable_rx) ? ST_PRE : ST_DROP;
				end
				ST_PRE: begin
					if (!eth_in_s)
						state <= ST_IDLE;
					else if (eth_in == SFD_OCT)
						state <= gap_ok ? ST_DATA : ST_DROP;
					else if (eth_in != PRE_OCT)
						state <= ST_DROP;
				end
				ST_DATA: begin
					if (!eth_in_s)
						state <= ST_IDLE;
					else if (at_max)
						state <= ST_DROP;
				end
				ST_DROP: begin
					// Swallow the rest of the frame
					if (!eth_in_s)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Gap counter runs through idle and preamble, saturates once legal
	always_ff @(posedge clk) begin
		if (!rst_n)
			gap <= '0;
		else if (state == ST_IDLE || state == ST_PRE) begin
			if (!gap_ok)
				gap <= gap + 1'b1;
		end else
			gap <= '0;
	end

	// Index of the next data octet
	always_ff @(posedge clk) begin
		if (!rst_n)
			cnt <= '0;
		else if (state != ST_DATA)
			cnt <= '0;
		else if (dat)
			cnt <= cnt + 1'b1;
	end

	always_ff @(posedge clk) begin
		d1 <= eth_in;
		e1 <= eth_in_e;
		idx1 <= cnt;
		octet <= d1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			ovf1 <= 1'b0;
			oct_v <= 1'b0;
			oct_first <= 1'b0;
			oct_last <= 1'b0;
			err2 <= 1'b0;
			idx <= '1;
			pack_len <= '0;
		end else begin
			v1 <= dat;
			ovf1 <= ovf_now;
			oct_v <= v1;
			oct_first <= v1 & (idx1 == '0);
			// Falls one cycle after the last forwarded octet
			oct_last <= oct_v & ~v1;
			err2 <= v1 & e1;
			// All ones between frames, so idx + 1 wraps to octet 0
			idx <= v1 ? idx1 : '1;
			if (v1)
				pack_len <= idx1 + 1'b1;
		end
	end

	// Oversize cut shows up as an error one cycle ahead of oct_last
	assign oct_err = err2 | ovf1;

	a_state_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(state));

endmodule

`default_nettype wire

// File: scan_pkg.sv
// Frame classifier shared definitions
// Octet offsets, config addresses, category codes and CRC residue
`default_nettype none

package scan_pkg;

	// Octet index width, covers MAX_FRAME
	localparam int CNT_W = 11;

	// Framing limits
	localparam int MAX_FRAME = 1536;
	localparam int IFG_MIN = 10;

	// Category codes in status_vec[1:0]
	localparam logic [1:0] CAT_OTHER = 2'd0;
	localparam logic [1:0] CAT_ARP = 2'd1;
	localparam logic [1:0] CAT_ICMP = 2'd2;
	localparam logic [1:0] CAT_UDP = 2'd3;

	// Octet offsets after the SFD
	localparam int OFF_DST_MAC = 0;
	localparam int OFF_SRC_MAC = 6;
	localparam int OFF_IP_DST = 30;
	localparam int OFF_UDP_DPORT = 36;
	localparam int OFF_ARP_TIP = 38;

	// Config memory word addresses
	localparam logic [3:0] CFG_MAC_BASE = 4'd0;
	localparam logic [3:0] CFG_IP_BASE = 4'd8;

	// Reflected CRC-32 register after a good FCS, no final inversion
	localparam logic [31:0] CRC_RESIDUE = 32'hdebb20e3;

endpackage

`default_nettype wire
